// ==== source/mac_pkg.sv ====
package mac_pkg;

  typedef logic [7:0]  byte_t;
  // most significant octet goes out first
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ethertype_t;
  typedef logic [15:0] frame_len_t;
  typedef logic [31:0] crc_t;

  typedef struct packed {
    mac_addr_t  dst_mac_addr;
    mac_addr_t  src_mac_addr;
    ethertype_t ethertype;
  } mac_hdr_t;

  typedef struct packed {
    mac_addr_t mac_addr;
  } dev_t;

  // gmii-like byte lane
  typedef struct packed {
    byte_t d;
    logic  v;
    logic  e;
  } phy_t;

  // user side byte stream
  typedef struct packed {
    byte_t d;
    logic  v;
    logic  sof;
    logic  eof;
    logic  err;
  } strm_t;

  typedef enum logic [2:0] {
    idle_s,
    pre_s,
    dst_s,
    src_s,
    type_s,
    payload_s,
    fcs_s,
    gap_s
  } tx_fsm_t;

  localparam byte_t PREAMBLE_BYTE = 8'h55;
  localparam byte_t SFD_BYTE      = 8'hD5;
  localparam int    PREAMBLE_LEN  = 7;
  localparam int    HDR_LEN       = 14;
  localparam int    MIN_PAYLOAD   = 46;
  localparam int    FCS_LEN       = 4;
  localparam int    IFG_LEN       = 12;

  // register value after data plus a good fcs
  localparam crc_t  CRC_RESIDUE   = 32'hDEBB20E3;

endpackage

// ==== source/crc32.sv ====
module crc32 (
  input  logic           clk,
  input  logic           fsm_rst,
  input  logic           clr,
  input  logic           v,
  input  mac_pkg::byte_t d,
  output mac_pkg::crc_t  crc,
  output logic           ok
);
  import mac_pkg::*;

  // reflected ieee 802.3 polynomial
  localparam crc_t POLY = 32'hEDB88320;

  crc_t c;
  crc_t inv;

  function automatic crc_t crc_next(input crc_t cur, input byte_t din);
    crc_t r;
    r = cur;
    // lsb first, one bit per step
    for (int i = 0; i < 8; i++) begin
      r = (r[0] ^ din[i]) ? ((r >> 1) ^ POLY) : (r >> 1);
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst || clr) begin
      c <= '1;
    end else if (v) begin
      c <= crc_next(c, d);
    end
  end

  assign inv = ~c;
  // first byte on the wire sits in the top octet
  assign crc = {inv[7:0], inv[15:8], inv[23:16], inv[31:24]};
  assign ok  = (c == CRC_RESIDUE);

endmodule

// ==== source/tx_fifo.sv ====
module tx_fifo #(
  parameter int FIFO_AW = 6
) (
  input  logic           clk,
  input  logic           fsm_rst,
  input  logic           write,
  input  mac_pkg::byte_t din,
  input  logic           read,
  output mac_pkg::byte_t dout,
  output logic           empty,
  output logic           full
);
  import mac_pkg::*;

  localparam int DEPTH = 2 ** FIFO_AW;

  byte_t              mem [DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               do_wr;
  logic               do_rd;

  assign do_wr = write && !full;
  assign do_rd = read && !empty;
  assign empty = (count == '0);
  assign full  = (count == (FIFO_AW + 1)'(DEPTH));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage and registered read port
  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= din;
    if (do_rd) dout <= mem[rd_ptr];
  end

endmodule

// ==== source/mac_rx.sv ====
module mac_rx (
  input  logic                clk,
  input  logic                fsm_rst,
  input  mac_pkg::phy_t       phy_rx,
  output mac_pkg::strm_t      rx,
  output mac_pkg::mac_hdr_t   rx_hdr,
  output mac_pkg::frame_len_t rx_len
);
  import mac_pkg::*;

  typedef enum logic [1:0] {
    hunt_s,
    hdr_s,
    data_s
  } rx_fsm_t;

  // header plus fcs, also the count where the first payload byte leaves
  localparam frame_len_t MIN_FRAME = frame_len_t'(HDR_LEN + FCS_LEN);

  rx_fsm_t             state;
  logic                pre_seen;
  logic                v_q;
  frame_len_t          byte_cnt;
  mac_hdr_t            hdr_sr;
  byte_t [FCS_LEN-1:0] dly;
  logic  [FCS_LEN-1:0] dly_v;
  logic                err_seen;
  logic                fall_q;
  logic                in_frame;
  logic                frame_end;
  logic                fwd;
  logic                first;
  logic                short_frm;
  logic                crc_v;
  logic                crc_ok;

  assign in_frame  = (state != hunt_s);
  assign crc_v     = phy_rx.v && in_frame;
  assign frame_end = v_q && !phy_rx.v && in_frame;
  // a byte leaves only once four more frame bytes have arrived
  assign fwd       = phy_rx.v && dly_v[FCS_LEN-1];
  assign first     = fwd && (byte_cnt == MIN_FRAME);
  assign short_frm = (byte_cnt < MIN_FRAME);

  crc32 u_crc (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clr     (fall_q),
    .v       (crc_v),
    .d       (phy_rx.d),
    .crc     (),
    .ok      (crc_ok)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= hunt_s;
      pre_seen <= 1'b0;
      v_q      <= 1'b0;
      byte_cnt <= '0;
      dly_v    <= '0;
      err_seen <= 1'b0;
      fall_q   <= 1'b0;
    end else begin
      pre_seen <= phy_rx.v && (phy_rx.d == PREAMBLE_BYTE);
      v_q      <= phy_rx.v;
      fall_q   <= frame_end;
      dly_v    <= {dly_v[FCS_LEN-2:0], phy_rx.v && (state == data_s)};
      if (fall_q) begin
        err_seen <= 1'b0;
      end else if (phy_rx.v && phy_rx.e) begin
        err_seen <= 1'b1;
      end
      if (crc_v) byte_cnt <= byte_cnt + 1'b1;
      case (state)
        hunt_s: begin
          if (phy_rx.v && (phy_rx.d == SFD_BYTE) && pre_seen) begin
            state    <= hdr_s;
            byte_cnt <= '0;
          end
        end
        hdr_s: begin
          if (!phy_rx.v) begin
            state <= hunt_s;
          end else if (byte_cnt == frame_len_t'(HDR_LEN - 1)) begin
            state <= data_s;
          end
        end
        data_s: begin
          if (!phy_rx.v) state <= hunt_s;
        end
        default: state <= hunt_s;
      endcase
    end
  end

  // fcs hold-back line and header shifter
  always_ff @(posedge clk) begin
    dly <= {dly[FCS_LEN-2:0], phy_rx.d};
    if (phy_rx.v && (state == hdr_s)) begin
      hdr_sr <= {hdr_sr[8*HDR_LEN-9:0], phy_rx.d};
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rx     <= '0;
      rx_hdr <= '0;
      rx_len <= '0;
    end else begin
      rx.d   <= dly[FCS_LEN-1];
      rx.v   <= fwd;
      rx.sof <= first;
      rx.eof <= fall_q;
      rx.err <= fall_q && (!crc_ok || err_seen || short_frm);
      if (first) rx_hdr <= hdr_sr;
      if (fall_q) rx_len <= short_frm ? '0 : byte_cnt - MIN_FRAME;
    end
  end

endmodule

// ==== source/mac_tx.sv ====
module mac_tx #(
  parameter int FIFO_AW = 6
) (
  input  logic              clk,
  input  logic              fsm_rst,
  input  mac_pkg::dev_t     dev,
  input  mac_pkg::mac_hdr_t tx_hdr,
  input  logic              avl,
  output logic              busy,
  output logic              fifo_read,
  input  mac_pkg::byte_t    fifo_dout,
  input  logic              fifo_empty,
  output mac_pkg::phy_t     phy_tx
);
  import mac_pkg::*;

  // wide enough for a full fifo or the minimum payload
  localparam int PAD_W = $clog2(MIN_PAYLOAD + 1);
  localparam int PAY_W = (FIFO_AW + 1 > PAD_W) ? FIFO_AW + 1 : PAD_W;

  tx_fsm_t          state;
  logic [3:0]       byte_cnt;
  logic [PAY_W-1:0] pay_cnt;
  logic             rd_q;
  logic             start;
  mac_hdr_t         hdr_q;
  byte_t            tx_d;
  logic             tx_v;
  logic             crc_v;
  crc_t             crc;
  crc_t             fcs_sh;

  assign start  = (state == idle_s) && avl;
  assign busy   = (state != idle_s);
  // one read ahead, the chain stops at the first empty
  assign fifo_read = !fifo_empty &&
                     (((state == type_s) && (byte_cnt == 4'd1)) ||
                      ((state == payload_s) && rd_q));
  assign fcs_sh = crc << {byte_cnt[1:0], 3'b000};

  crc32 u_crc (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clr     (start),
    .v       (crc_v),
    .d       (tx_d),
    .crc     (crc),
    .ok      ()
  );

  always_comb begin
    tx_d  = '0;
    tx_v  = 1'b0;
    crc_v = 1'b0;
    case (state)
      pre_s: begin
        tx_v = 1'b1;
        tx_d = (byte_cnt == 4'(PREAMBLE_LEN)) ? SFD_BYTE : PREAMBLE_BYTE;
      end
      dst_s: begin
        tx_v  = 1'b1;
        crc_v = 1'b1;
        tx_d  = hdr_q.dst_mac_addr[47:40];
      end
      src_s: begin
        tx_v  = 1'b1;
        crc_v = 1'b1;
        tx_d  = hdr_q.src_mac_addr[47:40];
      end
      type_s: begin
        tx_v  = 1'b1;
        crc_v = 1'b1;
        tx_d  = hdr_q.ethertype[15:8];
      end
      payload_s: begin
        tx_v  = 1'b1;
        crc_v = 1'b1;
        // zero padding once the fifo has run dry
        tx_d  = rd_q ? fifo_dout : '0;
      end
      fcs_s: begin
        tx_v = 1'b1;
        tx_d = fcs_sh[31:24];
      end
      default: begin
        tx_v = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= idle_s;
      byte_cnt <= '0;
      pay_cnt  <= '0;
      rd_q     <= 1'b0;
      phy_tx   <= '0;
    end else begin
      rd_q     <= fifo_read;
      phy_tx.d <= tx_d;
      phy_tx.v <= tx_v;
      phy_tx.e <= 1'b0;
      byte_cnt <= byte_cnt + 1'b1;
      case (state)
        idle_s: begin
          byte_cnt <= '0;
          pay_cnt  <= '0;
          if (avl) state <= pre_s;
        end
        pre_s: begin
          if (byte_cnt == 4'(PREAMBLE_LEN)) begin
            state    <= dst_s;
            byte_cnt <= '0;
          end
        end
        dst_s: begin
          if (byte_cnt == 4'd5) begin
            state    <= src_s;
            byte_cnt <= '0;
          end
        end
        src_s: begin
          if (byte_cnt == 4'd5) begin
            state    <= type_s;
            byte_cnt <= '0;
          end
        end
        type_s: begin
          if (byte_cnt == 4'd1) begin
            state    <= payload_s;
            byte_cnt <= '0;
          end
        end
        payload_s: begin
          pay_cnt <= pay_cnt + 1'b1;
          if (!fifo_read && (pay_cnt >= PAY_W'(MIN_PAYLOAD - 1))) begin
            state    <= fcs_s;
            byte_cnt <= '0;
          end
        end
        fcs_s: begin
          if (byte_cnt == 4'(FCS_LEN - 1)) begin
            state    <= gap_s;
            byte_cnt <= '0;
          end
        end
        gap_s: begin
          if (byte_cnt == 4'(IFG_LEN)) state <= idle_s;
        end
        default: state <= idle_s;
      endcase
    end
  end

  // header latch, fields shift out msb first
  always_ff @(posedge clk) begin
    if (start) begin
      hdr_q.dst_mac_addr <= tx_hdr.dst_mac_addr;
      hdr_q.src_mac_addr <= dev.mac_addr;
      hdr_q.ethertype    <= tx_hdr.ethertype;
    end else begin
      case (state)
        dst_s:   hdr_q.dst_mac_addr <= hdr_q.dst_mac_addr << 8;
        src_s:   hdr_q.src_mac_addr <= hdr_q.src_mac_addr << 8;
        type_s:  hdr_q.ethertype    <= hdr_q.ethertype << 8;
        default: hdr_q <= hdr_q;
      endcase
    end
  end

endmodule

// ==== source/mac_top.sv ====
module mac_top #(
  parameter int FIFO_AW = 6
) (
  input  logic                clk,
  input  logic                fsm_rst,
  input  mac_pkg::phy_t       phy_rx,
  output mac_pkg::phy_t       phy_tx,
  output mac_pkg::strm_t      rx,
  output mac_pkg::mac_hdr_t   rx_hdr,
  output mac_pkg::frame_len_t rx_len,
  input  mac_pkg::strm_t      tx,
  input  mac_pkg::mac_hdr_t   tx_hdr,
  input  mac_pkg::dev_t       dev,
  input  logic                avl,
  output logic                busy
);
  import mac_pkg::*;

  logic  fifo_read;
  byte_t fifo_dout;
  logic  fifo_empty;

  mac_rx u_rx (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .phy_rx  (phy_rx),
    .rx      (rx),
    .rx_hdr  (rx_hdr),
    .rx_len  (rx_len)
  );

  // payload staging, full writes are dropped inside
  tx_fifo #(
    .FIFO_AW (FIFO_AW)
  ) u_fifo (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .write   (tx.v),
    .din     (tx.d),
    .read    (fifo_read),
    .dout    (fifo_dout),
    .empty   (fifo_empty),
    .full    ()
  );

  mac_tx #(
    .FIFO_AW (FIFO_AW)
  ) u_tx (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .dev        (dev),
    .tx_hdr     (tx_hdr),
    .avl        (avl),
    .busy       (busy),
    .fifo_read  (fifo_read),
    .fifo_dout  (fifo_dout),
    .fifo_empty (fifo_empty),
    .phy_tx     (phy_tx)
  );

endmodule

// ==== verification/mac_tb.sv ====
module mac_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import mac_pkg::*;

  localparam int NUM_FRAMES   = 24;
  // load, wire time and gap of the longest frame fit well inside this
  localparam int FRAME_CYCLES = 200;
  localparam int MAX_CYCLES   = (NUM_FRAMES + 6) * FRAME_CYCLES;

  logic       clk = 1'b0;
  logic       fsm_rst;
  phy_t       phy_rx;
  phy_t       phy_tx;
  strm_t      rx;
  mac_hdr_t   rx_hdr;
  frame_len_t rx_len;
  strm_t      tx;
  mac_hdr_t   tx_hdr;
  dev_t       dev;
  logic       avl;
  logic       busy;

  integer seed     = 64850;
  int     errors   = 0;
  int     cycles   = 0;
  int     wire_idx = 0;
  int     hit_idx  = -1;
  logic   flip_en  = 1'b0;
  logic   e_en     = 1'b0;

  mac_top #(
    .FIFO_AW (6)
  ) UUT (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .phy_rx  (phy_rx),
    .phy_tx  (phy_tx),
    .rx      (rx),
    .rx_hdr  (rx_hdr),
    .rx_len  (rx_len),
    .tx      (tx),
    .tx_hdr  (tx_hdr),
    .dev     (dev),
    .avl     (avl),
    .busy    (busy)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the frames did not complete within %0d cycles", MAX_CYCLES);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  // position of the current byte within a burst on phy_tx
  always @(posedge clk) begin
    wire_idx <= phy_tx.v ? wire_idx + 1 : 0;
  end

  // loopback with optional damage on one byte
  always_comb begin
    phy_rx = phy_tx;
    if (phy_tx.v && (wire_idx == hit_idx)) begin
      if (flip_en) phy_rx.d = ~phy_tx.d;
      if (e_en) phy_rx.e = 1'b1;
    end
  end

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // bitwise reflected crc-32 giving the complemented register
  function automatic crc_t fcs_of(input byte_t data[$]);
    crc_t c;
    c = 32'hFFFFFFFF;
    foreach (data[i]) begin
      c = c ^ {24'h000000, data[i]};
      for (int b = 0; b < 8; b++) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  task automatic expect_quiet(input string when);
    check(128'(busy), 128'(0), {"busy ", when});
    check(128'(phy_tx.v), 128'(0), {"phy_tx.v ", when});
    check(128'(rx.v), 128'(0), {"rx.v ", when});
    check(128'(rx.sof), 128'(0), {"rx.sof ", when});
    check(128'(rx.eof), 128'(0), {"rx.eof ", when});
    check(128'(rx.err), 128'(0), {"rx.err ", when});
  endtask

  // mode 0 good frame, 1 flipped payload byte, 2 forced error byte
  task automatic run_frame(input int mode);
    logic [31:0] rnd;
    int          len;
    int          pad_len;
    int          cyc;
    int          gap_cyc;
    int          eof_cnt;
    logic        v_seen;
    logic        v_done;
    logic        done;
    logic        err_got;
    frame_len_t  len_got;
    mac_hdr_t    hdr_got;
    mac_addr_t   dst;
    mac_addr_t   src;
    ethertype_t  typ;
    crc_t        fcs;
    byte_t       pay[$];
    byte_t       body[$];
    byte_t       exp_wire[$];
    byte_t       got_wire[$];
    byte_t       got_rx[$];

    rnd = $random(seed);
    len = 1 + int'(rnd[5:0]);
    pad_len = (len > MIN_PAYLOAD) ? len : MIN_PAYLOAD;
    rnd = $random(seed);
    dst[47:32] = rnd[15:0];
    rnd = $random(seed);
    dst[31:0] = rnd;
    rnd = $random(seed);
    src[47:32] = rnd[15:0];
    rnd = $random(seed);
    src[31:0] = rnd;
    rnd = $random(seed);
    typ = rnd[15:0];
    for (int i = 0; i < len; i++) begin
      rnd = $random(seed);
      pay.push_back(rnd[7:0]);
    end

    // expected frame with the msb octet of each field leading
    for (int i = 5; i >= 0; i--) begin
      body.push_back(dst[8*i +: 8]);
    end
    for (int i = 5; i >= 0; i--) begin
      body.push_back(src[8*i +: 8]);
    end
    body.push_back(typ[15:8]);
    body.push_back(typ[7:0]);
    for (int i = 0; i < pad_len; i++) begin
      body.push_back((i < len) ? pay[i] : 8'h00);
    end
    fcs = fcs_of(body);
    for (int i = 0; i < PREAMBLE_LEN; i++) begin
      exp_wire.push_back(PREAMBLE_BYTE);
    end
    exp_wire.push_back(SFD_BYTE);
    foreach (body[i]) begin
      exp_wire.push_back(body[i]);
    end
    for (int i = 0; i < FCS_LEN; i++) begin
      exp_wire.push_back(fcs[8*i +: 8]);
    end

    rnd = $random(seed);
    hit_idx = PREAMBLE_LEN + 1 + HDR_LEN + int'(rnd[15:0]) % pad_len;
    flip_en = (mode == 1);
    e_en = (mode == 2);

    tx_hdr.dst_mac_addr = dst;
    tx_hdr.src_mac_addr = ~src;
    tx_hdr.ethertype = typ;
    dev.mac_addr = src;
    foreach (pay[i]) begin
      @(negedge clk);
      tx.v = 1'b1;
      tx.d = pay[i];
    end
    @(negedge clk);
    tx.v = 1'b0;
    avl = 1'b1;
    @(negedge clk);
    avl = 1'b0;
    check(128'(busy), 128'(1), "busy the cycle after avl");
    check(128'(phy_tx.v), 128'(0), "phy_tx.v one cycle after avl");

    cyc = 0;
    gap_cyc = 0;
    eof_cnt = 0;
    v_seen = 1'b0;
    v_done = 1'b0;
    done = 1'b0;
    err_got = 1'b0;
    len_got = '0;
    hdr_got = '0;
    while (!done) begin
      @(negedge clk);
      cyc++;
      if (cyc == 1) begin
        check(128'(phy_tx.v), 128'(1), "phy_tx.v two cycles after avl");
      end
      check(128'(phy_tx.e), 128'(0), "phy_tx.e");
      if (phy_tx.v) begin
        check(128'(v_done), 128'(0), "phy_tx.v high again after the frame");
        v_seen = 1'b1;
        got_wire.push_back(phy_tx.d);
      end else if (v_seen) begin
        v_done = 1'b1;
      end
      if (v_done && busy) gap_cyc++;
      if (rx.v) begin
        check(128'(rx.sof), 128'(got_rx.size() == 0), "rx.sof on the first byte only");
        got_rx.push_back(rx.d);
      end
      if (rx.eof) begin
        eof_cnt++;
        err_got = rx.err;
        len_got = rx_len;
        hdr_got = rx_hdr;
      end
      if (!busy) begin
        check(128'(gap_cyc), 128'(IFG_LEN), "idle cycles from frame end to busy fall");
        done = 1'b1;
      end
      // extra pulse during the preamble
      avl = (cyc == 3);
    end
    flip_en = 1'b0;
    e_en = 1'b0;

    check(128'(got_wire.size()), 128'(exp_wire.size()), "byte count on phy_tx");
    foreach (exp_wire[i]) begin
      check(128'(got_wire[i]), 128'(exp_wire[i]), "byte on phy_tx");
    end
    check(128'(eof_cnt), 128'(1), "rx.eof pulses per frame");
    if (mode == 0) begin
      check(128'(err_got), 128'(0), "rx.err on a good frame");
      check(128'(len_got), 128'(pad_len), "rx_len");
      check(128'(hdr_got), 128'({dst, src, typ}), "rx_hdr");
      check(128'(got_rx.size()), 128'(pad_len), "byte count on rx");
      for (int i = 0; i < pad_len; i++) begin
        check(128'(got_rx[i]), 128'(body[HDR_LEN + i]), "payload byte on rx");
      end
    end else begin
      check(128'(err_got), 128'(1), "rx.err on a damaged frame");
    end
    repeat (3) begin
      @(negedge clk);
      check(128'(busy), 128'(0), "busy after the gap");
      check(128'(phy_tx.v), 128'(0), "phy_tx.v after the gap");
    end
  endtask

  initial begin
    fsm_rst = 1'b1;
    tx = '0;
    tx_hdr = '0;
    dev = '0;
    avl = 1'b0;
    repeat (16) begin
      @(negedge clk);
      expect_quiet("during reset");
    end
    fsm_rst = 1'b0;
    @(negedge clk);
    expect_quiet("after reset");
    for (int f = 0; f < NUM_FRAMES; f++) begin
      run_frame((f % 6 == 4) ? 1 : ((f % 6 == 5) ? 2 : 0));
    end
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
source/mac_pkg.sv
source/crc32.sv
source/tx_fifo.sv
source/mac_rx.sv
source/mac_tx.sv
source/mac_top.sv
verification/mac_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mac_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
